/* all.f */
src/vstat_pkg.sv
src/vstat_fp_add.sv
src/vstat_fp_red_sum.sv
src/vstat_fp_red_max.sv
src/vstat_join.sv
src/vstat_top.sv
verification/vstat_chk.sv
verification/vstat_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module vstat_tb -o vstat_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vstat_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* src/vstat_fp_add.sv */
`timescale 1ns/1ps
`default_nettype none

module vstat_fp_add
import vstat_pkg::*;
(
    input   acc_fp_t    a_i     ,
    input   acc_fp_t    b_i     ,
    output  acc_fp_t    sum_o
);

    logic               a_zero;
    logic               b_zero;
    logic [23 : 0]      man_a;
    logic [23 : 0]      man_b;
    logic               a_big;
    logic               sign_big;
    logic               eff_sub;
    logic [7 : 0]       exp_big;
    logic [7 : 0]       exp_diff;
    logic [26 : 0]      big_ext;
    logic [26 : 0]      small_ext;
    logic [26 : 0]      small_sh;
    logic [27 : 0]      sum_mag;
    logic [4 : 0]       lz;
    logic [27 : 0]      norm;
    logic signed [9 : 0] exp_res;

    // a zero exponent field means zero or denormal, both read as zero
    assign a_zero = (a_i[30 : 23] == 8'd0);
    assign b_zero = (b_i[30 : 23] == 8'd0);

    assign man_a = a_zero ? 24'd0 : {1'b1, a_i[22 : 0]};
    assign man_b = b_zero ? 24'd0 : {1'b1, b_i[22 : 0]};

    assign a_big    = ({a_i[30 : 23], man_a} >= {b_i[30 : 23], man_b});    // magnitude order
    assign sign_big = a_big ? a_i[31] : b_i[31];
    assign exp_big  = a_big ? a_i[30 : 23] : b_i[30 : 23];
    assign exp_diff = a_big ? (a_i[30 : 23] - b_i[30 : 23])
                            : (b_i[30 : 23] - a_i[30 : 23]);

    // three guard bits, bits shifted past them are simply dropped
    assign big_ext   = {a_big ? man_a : man_b, 3'b000};
    assign small_ext = {a_big ? man_b : man_a, 3'b000};
    assign small_sh  = small_ext >> exp_diff;

    assign eff_sub = a_i[31] ^ b_i[31];

    // the big operand is never smaller so the difference stays positive
    assign sum_mag = eff_sub ? ({1'b0, big_ext} - {1'b0, small_sh})
                             : ({1'b0, big_ext} + {1'b0, small_sh});

    always_comb begin
        lz = 5'd28;
        for (int i = 0; i < 28; i++) begin
            if (sum_mag[i]) begin
                lz = 5'(27 - i);    // highest set bit is the last one to hit
            end
        end
    end

    assign norm    = sum_mag << lz;
    assign exp_res = $signed({2'b00, exp_big}) + 10'sd1 - $signed({5'd0, lz});

    // truncation keeps the bits below the leading one and drops the rest
    always_comb begin
        if (sum_mag == 28'd0 || exp_res <= 10'sd0) begin
            sum_o = '0;    // exact cancellation and underflow both give +0
        end else if (exp_res >= 10'sd255) begin
            sum_o = {sign_big, 8'hff, 23'd0};
        end else begin
            sum_o = {sign_big, exp_res[7 : 0], norm[26 : 4]};
        end
    end

endmodule

`default_nettype wire

/* src/vstat_fp_red_max.sv */
`timescale 1ns/1ps
`default_nettype none

module vstat_fp_red_max
import vstat_pkg::*;
(
    input   logic       clk_i       ,
    input   logic       rst_i       ,
    input   logic       valid_i     ,
    input   strb_t      strb_i      ,
    input   vect_t      vect_i      ,
    output  logic       valid_o     ,
    output  in_fp_t     res_o
);

    in_fp_t                 lane [VECT_WIDTH];
    in_fp_t                 win_lo;
    in_fp_t                 win_hi;
    in_fp_t                 winner;
    logic [MAX_LAT - 1 : 0] valid_q;

    // sign-magnitude order, +0 and -0 are equal
    function automatic logic bf16_gt(in_fp_t a, in_fp_t b);
        if (a[14 : 0] == 15'd0 && b[14 : 0] == 15'd0) begin
            return 1'b0;
        end
        if (a[15] != b[15]) begin
            return b[15];
        end
        if (!a[15]) begin
            return a[14 : 0] > b[14 : 0];
        end
        return a[14 : 0] < b[14 : 0];
    endfunction

    // disabled lanes lose every compare, denormals keep only their sign
    for (genvar i = 0; i < VECT_WIDTH; i++) begin : gen_lane
        assign lane[i] = !strb_i[i] ? BF16_NEG_INF
                       : (vect_i[i * IN_WIDTH + 7 +: 8] == 8'd0)
                         ? {vect_i[i * IN_WIDTH + 15], 15'd0}
                         : vect_i[i * IN_WIDTH +: IN_WIDTH];
    end

    // the upper lane has to be strictly larger to win a tie
    assign win_lo = bf16_gt(lane[1], lane[0]) ? lane[1] : lane[0];
    assign win_hi = bf16_gt(lane[3], lane[2]) ? lane[3] : lane[2];
    assign winner = bf16_gt(win_hi, win_lo) ? win_hi : win_lo;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= MAX_LAT'({valid_q, valid_i});
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            res_o <= winner;
        end
    end

    assign valid_o = valid_q[MAX_LAT - 1];

endmodule

`default_nettype wire

/* src/vstat_fp_red_sum.sv */
`timescale 1ns/1ps
`default_nettype none

module vstat_fp_red_sum
import vstat_pkg::*;
(
    input   logic       clk_i       ,
    input   logic       rst_i       ,
    input   logic       valid_i     ,
    input   strb_t      strb_i      ,
    input   vect_t      vect_i      ,
    input   tag_t       tag_i       ,
    output  logic       valid_o     ,
    output  acc_fp_t    res_o       ,
    output  tag_t       tag_o
);

    acc_fp_t                lane_wide [VECT_WIDTH];
    acc_fp_t                pair_sum [2];
    acc_fp_t                pair_q [2];
    acc_fp_t                total;
    tag_t                   tag_q;
    logic [SUM_LAT - 1 : 0] valid_q;

    // widening bfloat16 to binary32 only pads the low mantissa bits
    for (genvar i = 0; i < VECT_WIDTH; i++) begin : gen_widen
        assign lane_wide[i] = strb_i[i]
            ? {vect_i[i * IN_WIDTH +: IN_WIDTH], {(ACC_WIDTH - IN_WIDTH){1'b0}}}
            : '0;
    end

    for (genvar p = 0; p < 2; p++) begin : gen_pair_add
        vstat_fp_add i_pair_add (
            .a_i    (   lane_wide[2 * p]        ),
            .b_i    (   lane_wide[2 * p + 1]    ),
            .sum_o  (   pair_sum[p]             )
        );
    end

    vstat_fp_add i_final_add (
        .a_i    (   pair_q[0]   ),
        .b_i    (   pair_q[1]   ),
        .sum_o  (   total       )
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= SUM_LAT'({valid_q, valid_i});    // one bit per stage
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            pair_q[0] <= pair_sum[0];
            pair_q[1] <= pair_sum[1];
            tag_q     <= tag_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_q[0]) begin
            res_o <= total;
            tag_o <= tag_q;
        end
    end

    assign valid_o = valid_q[SUM_LAT - 1];

endmodule

`default_nettype wire

/* src/vstat_join.sv */
`timescale 1ns/1ps
`default_nettype none

module vstat_join
import vstat_pkg::*;
(
    input   logic       clk_i           ,
    input   logic       rst_i           ,
    input   logic       sum_valid_i     ,
    input   acc_fp_t    sum_i           ,
    input   tag_t       tag_i           ,
    input   logic       max_valid_i     ,
    input   in_fp_t     max_i           ,
    input   logic       out_credit_i    ,
    output  logic       valid_o         ,
    output  acc_fp_t    sum_o           ,
    output  in_fp_t     max_o           ,
    output  tag_t       tag_o           ,
    output  logic       in_credit_o
);

    // max results wait here for the slower sum of the same beat
    in_fp_t     max_buf [SUM_LAT - MAX_LAT + 1];
    logic       mb_wr;
    logic       mb_rd;

    acc_fp_t    q_sum [IN_CREDITS];
    in_fp_t     q_max [IN_CREDITS];
    tag_t       q_tag [IN_CREDITS];

    logic [$clog2(IN_CREDITS) - 1 : 0]  q_wr;
    logic [$clog2(IN_CREDITS) - 1 : 0]  q_rd;

    cnt_t       queue_cnt;
    cnt_t       credit_cnt;    // downstream credits currently held
    logic       pop;

    always_ff @(posedge clk_i) begin
        if (max_valid_i) begin
            max_buf[mb_wr] <= max_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mb_wr <= 1'b0;
            mb_rd <= 1'b0;
        end else begin
            if (max_valid_i) begin
                mb_wr <= ~mb_wr;
            end
            if (sum_valid_i) begin
                mb_rd <= ~mb_rd;
            end
        end
    end

    // a pair is queued in the cycle its sum arrives
    always_ff @(posedge clk_i) begin
        if (sum_valid_i) begin
            q_sum[q_wr] <= sum_i;
            q_max[q_wr] <= max_buf[mb_rd];
            q_tag[q_wr] <= tag_i;
        end
    end

    assign pop = (queue_cnt != '0) && (credit_cnt != '0);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            q_wr       <= '0;
            q_rd       <= '0;
            queue_cnt  <= '0;
            credit_cnt <= cnt_t'(OUT_CREDITS);
        end else begin
            if (sum_valid_i) begin
                q_wr <= q_wr + 1'b1;
            end
            if (pop) begin
                q_rd <= q_rd + 1'b1;
            end
            queue_cnt  <= queue_cnt + cnt_t'(sum_valid_i) - cnt_t'(pop);
            credit_cnt <= credit_cnt + cnt_t'(out_credit_i) - cnt_t'(pop);    // send and return may coincide
        end
    end

    assign valid_o     = pop;
    assign sum_o       = q_sum[q_rd];
    assign max_o       = q_max[q_rd];
    assign tag_o       = q_tag[q_rd];
    assign in_credit_o = pop;    // each result leaving frees one upstream slot

endmodule

`default_nettype wire

/* src/vstat_pkg.sv */
`default_nettype none

package vstat_pkg;

    localparam int unsigned VECT_WIDTH  = 4;
    localparam int unsigned IN_WIDTH    = 16;    // bfloat16
    localparam int unsigned ACC_WIDTH   = 32;    // binary32
    localparam int unsigned TAG_WIDTH   = 8;

    // upstream beats in flight, also sizes the result queue
    localparam int unsigned IN_CREDITS  = 4;
    localparam int unsigned OUT_CREDITS = 2;

    localparam int unsigned SUM_LAT     = 2;
    localparam int unsigned MAX_LAT     = 1;

    typedef logic [IN_WIDTH - 1 : 0]                 in_fp_t;
    typedef logic [ACC_WIDTH - 1 : 0]                acc_fp_t;
    typedef logic [VECT_WIDTH - 1 : 0]               strb_t;
    typedef logic [VECT_WIDTH * IN_WIDTH - 1 : 0]    vect_t;
    typedef logic [TAG_WIDTH - 1 : 0]                tag_t;

    // holds 0 to IN_CREDITS inclusive
    typedef logic [$clog2(IN_CREDITS + 1) - 1 : 0]   cnt_t;

    localparam in_fp_t BF16_NEG_INF = 16'hff80;    // max of an all-disabled beat

endpackage

`default_nettype wire

/* src/vstat_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vstat_top
import vstat_pkg::*;
(
    input   logic       clk_i           ,
    input   logic       rst_i           ,
    input   logic       valid_i         ,
    input   strb_t      strb_i          ,
    input   vect_t      vect_i          ,
    input   tag_t       tag_i           ,
    input   logic       out_credit_i    ,
    output  logic       valid_o         ,
    output  acc_fp_t    sum_o           ,
    output  in_fp_t     max_o           ,
    output  tag_t       tag_o           ,
    output  logic       in_credit_o
);

    logic       sum_valid;
    acc_fp_t    sum_res;
    tag_t       sum_tag;
    logic       max_valid;
    in_fp_t     max_res;

    vstat_fp_red_sum i_red_sum (
        .clk_i      (   clk_i       ),
        .rst_i      (   rst_i       ),
        .valid_i    (   valid_i     ),
        .strb_i     (   strb_i      ),
        .vect_i     (   vect_i      ),
        .tag_i      (   tag_i       ),
        .valid_o    (   sum_valid   ),
        .res_o      (   sum_res     ),
        .tag_o      (   sum_tag     )
    );

    vstat_fp_red_max i_red_max (
        .clk_i      (   clk_i       ),
        .rst_i      (   rst_i       ),
        .valid_i    (   valid_i     ),
        .strb_i     (   strb_i      ),
        .vect_i     (   vect_i      ),
        .valid_o    (   max_valid   ),
        .res_o      (   max_res     )
    );

    vstat_join i_join (
        .clk_i          (   clk_i           ),
        .rst_i          (   rst_i           ),
        .sum_valid_i    (   sum_valid       ),
        .sum_i          (   sum_res         ),
        .tag_i          (   sum_tag         ),
        .max_valid_i    (   max_valid       ),
        .max_i          (   max_res         ),
        .out_credit_i   (   out_credit_i    ),
        .valid_o        (   valid_o         ),
        .sum_o          (   sum_o           ),
        .max_o          (   max_o           ),
        .tag_o          (   tag_o           ),
        .in_credit_o    (   in_credit_o     )
    );

endmodule

`default_nettype wire

/* verification/vstat_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module vstat_chk
import vstat_pkg::*;
(
    input   logic   clk_i           ,
    input   logic   rst_i           ,
    input   logic   valid_i         ,
    input   logic   in_credit_i     ,
    input   logic   out_credit_i    ,
    input   cnt_t   queue_cnt_i
);

    int unsigned    sent_cnt;    // results sent since reset
    int unsigned    back_cnt;    // downstream credits returned since reset

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sent_cnt <= '0;
            back_cnt <= '0;
        end else begin
            sent_cnt <= sent_cnt + 32'(valid_i);
            back_cnt <= back_cnt + 32'(out_credit_i);
        end
    end

    // credits held are the initial grant plus the returns minus the sends
    send_needs_credit: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_i |-> (sent_cnt < OUT_CREDITS + back_cnt))
        else $error("valid_o is high while no downstream credit is held");

    // upstream credits keep the queue from ever growing past its depth
    queue_bounded: assert property (@(posedge clk_i) disable iff (rst_i)
        queue_cnt_i <= cnt_t'(IN_CREDITS))
        else $error("result queue holds more than IN_CREDITS entries");

    quiet_after_reset: assert property (@(posedge clk_i)
        rst_i |=> (!valid_i && !in_credit_i))
        else $error("valid_o or in_credit_o high right after reset");

endmodule

bind vstat_join vstat_chk vstat_chk_inst (
    .clk_i          (   clk_i           ),
    .rst_i          (   rst_i           ),
    .valid_i        (   valid_o         ),
    .in_credit_i    (   in_credit_o     ),
    .out_credit_i   (   out_credit_i    ),
    .queue_cnt_i    (   queue_cnt       )
);

`default_nettype wire

/* verification/vstat_golden.txt */
# strb lane0 lane1 lane2 lane3 tag sum max, all hex, lanes bfloat16
# sum is binary32 from (lane0 + lane1) + (lane2 + lane3), truncated, max is bfloat16
f 3f80 4000 4040 4080 01 41200000 4080
f 3f80 bf80 4000 c000 02 00000000 4000
f bf80 c000 bf00 c040 03 c0d00000 bf00
f 4120 c000 3f00 bf80 04 40f00000 4120
3 3f80 4000 4040 4080 15 40400000 4000
c 3f80 4000 4040 4080 26 40e00000 4080
5 3f80 4000 4040 4080 37 40800000 4040
0 4120 42c8 3f80 4000 48 00000000 ff80
8 4120 4120 4120 bf00 59 bf000000 bf00
6 42c8 3f80 bf80 4000 6a 00000000 3f80
f 0001 3f80 8040 4000 7b 40400000 4000
5 8001 4000 0003 4000 8c 00000000 8000
3 00c0 8080 3f80 3f80 9d 00000000 00c0
3 7f7f 7f7f 3f80 3f80 ae 7f800000 7f7f
9 ff7f 3f80 3f80 ff7f bf ff800000 ff7f
f 3f80 3380 3380 3380 c0 3f800001 3f80
f 42c8 c2c8 3e80 be80 d1 00000000 42c8
f 3fc0 3fc0 bf00 3e80 e2 40300000 3fc0
f c080 c000 c040 bf80 f3 c1200000 bf80
4 3f80 3f80 42c8 3f80 04 42c80000 42c8
a 4000 c080 4000 3f00 ff c0600000 3f00
f 4100 4100 4100 4100 00 42000000 4100

/* verification/vstat_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vstat_tb
import vstat_pkg::*;
();

    localparam int CREDIT_TIMEOUT = 200;    // cycles one beat may wait for an upstream credit
    localparam int IDLE_TIMEOUT   = 300;    // cycles without any result still owed a credit

    logic       clk_i;
    logic       rst_i;
    logic       valid_i;
    strb_t      strb_i;
    vect_t      vect_i;
    tag_t       tag_i;
    logic       out_credit_i;
    logic       valid_o;
    acc_fp_t    sum_o;
    in_fp_t     max_o;
    tag_t       tag_o;
    logic       in_credit_o;

    strb_t      g_strb [$];
    vect_t      g_vect [$];
    tag_t       g_tag [$];
    acc_fp_t    g_sum [$];
    in_fp_t     g_max [$];

    int         n_beats;
    int         sent_beats = 0;
    int         in_credit_cnt = 0;    // upstream credits seen at the port
    int         result_cnt = 0;
    int         returned = 0;         // downstream credits handed back so far
    int         seed = 84;

    vstat_top vstat_top_inst (
        .clk_i          (   clk_i           ),
        .rst_i          (   rst_i           ),
        .valid_i        (   valid_i         ),
        .strb_i         (   strb_i          ),
        .vect_i         (   vect_i          ),
        .tag_i          (   tag_i           ),
        .out_credit_i   (   out_credit_i    ),
        .valid_o        (   valid_o         ),
        .sum_o          (   sum_o           ),
        .max_o          (   max_o           ),
        .tag_o          (   tag_o           ),
        .in_credit_o    (   in_credit_o     )
    );

    always #2 clk_i = ~clk_i;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_sum(input acc_fp_t got, input acc_fp_t exp, input int idx);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: beat %0d sum %h, expected %h", $time, idx, got, exp));
        end
    endtask

    task automatic check_max(input in_fp_t got, input in_fp_t exp, input int idx);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: beat %0d max %h, expected %h", $time, idx, got, exp));
        end
    endtask

    task automatic check_tag(input tag_t got, input tag_t exp, input int idx);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: beat %0d tag %h, expected %h", $time, idx, got, exp));
        end
    endtask

    task automatic load_golden();
        int         fd;
        int         n;
        string      line;
        strb_t      s;
        in_fp_t     lane [VECT_WIDTH];
        tag_t       t;
        acc_fp_t    sm;
        in_fp_t     mx;
        fd = $fopen("verification/vstat_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verification/vstat_golden.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 8 || line[0] == 8'h23) begin
                continue;    // blank line or column description
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h", s, lane[0], lane[1], lane[2], lane[3],
                        t, sm, mx);
            if (n != 8) begin
                abort_run($sformatf("golden line could not be read: %s", line));
            end
            g_strb.push_back(s);
            g_vect.push_back({lane[3], lane[2], lane[1], lane[0]});
            g_tag.push_back(t);
            g_sum.push_back(sm);
            g_max.push_back(mx);
        end
        $fclose(fd);
        n_beats = g_strb.size();
        if (n_beats == 0) begin
            abort_run("the golden file holds no beats");
        end
    endtask

    // sends back to back as long as the upstream credit allows
    task automatic send_beats();
        int waited;
        for (int i = 0; i < n_beats; i++) begin
            waited = 0;
            while (sent_beats - in_credit_cnt >= int'(IN_CREDITS)) begin
                @(posedge clk_i);
                #1;
                waited++;
                if (waited > CREDIT_TIMEOUT) begin
                    abort_run($sformatf("beat %0d waited too long for an upstream credit", i));
                end
            end
            valid_i    = 1'b1;
            strb_i     = g_strb[i];
            vect_i     = g_vect[i];
            tag_i      = g_tag[i];
            sent_beats = sent_beats + 1;
            @(posedge clk_i);
            #1;
            valid_i = 1'b0;
        end
    endtask

    task automatic return_credits();
        int idle;
        int delay;
        idle = 0;
        while (result_cnt < n_beats) begin
            if (result_cnt - returned > 0) begin
                delay = $unsigned($random(seed)) % 4;
                if (returned == 5 || ($random(seed) & 15) == 0) begin
                    delay = 30;    // long gap so the queue fills and the sender stalls
                end
                repeat (delay) begin
                    @(posedge clk_i);
                    #1;
                end
                out_credit_i = 1'b1;
                returned     = returned + 1;
                @(posedge clk_i);
                #1;
                out_credit_i = 1'b0;
                idle         = 0;
            end else begin
                @(posedge clk_i);
                #1;
                idle++;
                if (idle > IDLE_TIMEOUT) begin
                    abort_run("no result came out of the DUT for too long");
                end
            end
        end
    endtask

    // outputs settle after the rising edge, so they are read on the falling one
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (valid_o) begin
                if (result_cnt >= n_beats) begin
                    abort_run("a result came out with no beat outstanding");
                end
                check_sum(sum_o, g_sum[result_cnt], result_cnt);
                check_max(max_o, g_max[result_cnt], result_cnt);
                check_tag(tag_o, g_tag[result_cnt], result_cnt);
                result_cnt = result_cnt + 1;
            end
            if (in_credit_o === 1'b1) begin
                in_credit_cnt = in_credit_cnt + 1;
            end
            if (in_credit_o !== valid_o) begin
                abort_run("in_credit_o does not follow valid_o");
            end
            if (in_credit_cnt > sent_beats) begin
                abort_run("an upstream credit came back for a beat that was never sent");
            end
            if (result_cnt > int'(OUT_CREDITS) + returned) begin
                abort_run("more results were sent than the downstream credits allow");
            end
        end
    end

    initial begin
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        valid_i      = 1'b0;
        strb_i       = '0;
        vect_i       = '0;
        tag_i        = '0;
        out_credit_i = 1'b0;
        load_golden();
        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        fork
            send_beats();
            return_credits();
        join
        if (result_cnt == n_beats && in_credit_cnt == n_beats) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("result and credit counts do not match the number of beats");
        end
    end

endmodule

`default_nettype wire
